// File: lsuCore.f
+incdir+src
src/lsuPkg.sv
src/storeQueue.sv
src/memArbiter.sv
src/dataRam.sv
src/loadPipeline.sv
src/lsuTop.sv
verif/lsuTb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for a failure.
cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
    verilator --binary --timing -Wno-fatal -f lsuCore.f --top-module lsuTb -o lsuSim &&
    ./obj_dir/lsuSim 2>&1 | tee sim.log &&
    test -s sim.log &&
    ! grep -q "Result: FAILED" sim.log &&
    echo "simulation run clean" ||
    { echo "simulation run failed"; exit 1; }

// File: src/dataRam.sv
`timescale 1ns/1ns
`include "lsu_settings.svh"

module dataRam import lsuPkg::*; (
    input  logic  clk,
    input  MemReq req,
    output Word   rdata
);

    localparam int AW = $clog2(`LSU_RAM_WORDS);

    Word mem [`LSU_RAM_WORDS];

    initial begin
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.wmask[b]) begin
                        mem[req.wordAddr[AW-1:0]][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[req.wordAddr[AW-1:0]];
            end
        end
    end

endmodule

// File: src/loadPipeline.sv
`timescale 1ns/1ns

module loadPipeline import lsuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  LoadUop     load,
    input  BranchFlush branch,
    input  FwdLookup   fwd,
    output MemReq      memReq,
    input  Word        rdata,
    output LoadResult  result
);

    typedef struct packed {
        LoadUop uop;
        FwdLookup fwd;
    } Stage0;

    Stage0 stage0;

    logic inKeep;
    logic s0Keep;
    logic fullFwd;
    logic skip;
    LoadUop selUop;
    FwdLookup selFwd;
    Word ramData;
    Word merged;

    function automatic Word extractLoad(Word data, logic [1:0] offset, LoadSize size,
                                        logic signExtend);
        logic [7:0] b;
        logic [15:0] h;
        Word res;
        b = data[8*offset +: 8];
        h = offset[1] ? data[31:16] : data[15:0];
        case (size)
            SIZE_BYTE: res = {{24{signExtend & b[7]}}, b};
            SIZE_HALF: res = {{16{signExtend & h[15]}}, h};
            default:   res = data;
        endcase
        return res;
    endfunction

    assign inKeep = load.valid && !(branch.taken && isYounger(load.sqN, branch.sqN));
    assign s0Keep = stage0.uop.valid && !(branch.taken && isYounger(stage0.uop.sqN, branch.sqN));
    assign fullFwd = (fwd.mask == 4'b1111);

    // a load that the store queue covers completely writes back a cycle early.
    assign skip = inKeep && fullFwd && !s0Keep;

    always_comb begin
        memReq.valid = inKeep && !fullFwd;
        memReq.we = 1'b0;
        memReq.wordAddr = load.addr[31:2];
        memReq.wdata = '0;
        memReq.wmask = '0;
    end

    // stage 0 has priority because the RAM word for it arrives this cycle.
    always_comb begin
        if (s0Keep) begin
            selUop = stage0.uop;
            selFwd = stage0.fwd;
            ramData = rdata;
        end else begin
            selUop = load;
            selFwd = fwd;
            ramData = '0;
        end
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = selFwd.mask[b] ? selFwd.data[8*b +: 8] : ramData[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage0.uop.valid <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            if (inKeep && !skip) begin
                stage0.uop <= load;
                stage0.fwd <= fwd;
            end else begin
                stage0.uop.valid <= 1'b0;
            end
            result.valid <= s0Keep || skip;
            result.result <= extractLoad(merged, selUop.addr[1:0], selUop.size,
                                         selUop.signExtend);
            result.tagDst <= selUop.tagDst;
            result.sqN <= selUop.sqN;
        end
    end

endmodule

// File: src/lsuPkg.sv
`include "lsu_settings.svh"

package lsuPkg;

    typedef logic [31:0] Word;
    typedef logic [31:0] Addr;
    typedef logic [3:0] ByteMask;
    typedef logic [`LSU_TAG_W-1:0] Tag;
    typedef logic [`LSU_SQN_W-1:0] SqN;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } LoadSize;

    // sqN is that of the youngest store older than the load.
    typedef struct packed {
        logic valid;
        Addr addr;
        LoadSize size;
        logic signExtend;
        Tag tagDst;
        SqN sqN;
    } LoadUop;

    typedef struct packed {
        logic valid;
        Addr addr;
        Word data;
        ByteMask wmask;
        SqN sqN;
    } StoreUop;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchFlush;

    typedef struct packed {
        logic valid;
        Word result;
        Tag tagDst;
        SqN sqN;
    } LoadResult;

    typedef struct packed {
        ByteMask mask;
        Word data;
    } FwdLookup;

    typedef struct packed {
        logic valid;
        logic we;
        logic [29:0] wordAddr;
        Word wdata;
        ByteMask wmask;
    } MemReq;

    // sequence numbers wrap, so age is the sign of the difference.
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

// File: src/lsuTop.sv
`timescale 1ns/1ns

module lsuTop import lsuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  LoadUop     load,
    input  StoreUop    store,
    output logic       stStall,
    input  logic       commitValid,
    input  SqN         commitSqN,
    input  BranchFlush branch,
    output LoadResult  result
);

    FwdLookup fwd;
    MemReq loadReq;
    MemReq drainReq;
    MemReq ramReq;
    logic drainGrant;
    Word rdata;

    storeQueue u_storeQueue (
        .clk(clk),
        .rst(rst),
        .store(store),
        .stStall(stStall),
        .commitValid(commitValid),
        .commitSqN(commitSqN),
        .branch(branch),
        .lookupAddr(load.addr),
        .lookupSqN(load.sqN),
        .fwd(fwd),
        .drainReq(drainReq),
        .drainGrant(drainGrant)
    );

    loadPipeline u_loadPipeline (
        .clk(clk),
        .rst(rst),
        .load(load),
        .branch(branch),
        .fwd(fwd),
        .memReq(loadReq),
        .rdata(rdata),
        .result(result)
    );

    memArbiter u_memArbiter (
        .loadReq(loadReq),
        .drainReq(drainReq),
        .drainGrant(drainGrant),
        .ramReq(ramReq)
    );

    dataRam u_dataRam (
        .clk(clk),
        .req(ramReq),
        .rdata(rdata)
    );

endmodule

// File: src/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// number of entries in the speculative store queue.
`define LSU_SQ_DEPTH 4

// size of the data RAM in 32-bit words.
`define LSU_RAM_WORDS 256

`define LSU_TAG_W 6
`define LSU_SQN_W 6

`endif

// File: src/memArbiter.sv
`timescale 1ns/1ns

module memArbiter import lsuPkg::*; (
    input  MemReq loadReq,
    input  MemReq drainReq,
    output logic  drainGrant,
    output MemReq ramReq
);

    // loads always win and a drain only gets the port in a cycle without a load.
    assign drainGrant = drainReq.valid && !loadReq.valid;

    always_comb begin
        if (loadReq.valid) begin
            ramReq = loadReq;
        end else begin
            ramReq = drainReq;
        end
    end

endmodule

// File: src/storeQueue.sv
`timescale 1ns/1ns
`include "lsu_settings.svh"

module storeQueue import lsuPkg::*; #(
    parameter int DEPTH = `LSU_SQ_DEPTH
) (
    input  logic       clk,
    input  logic       rst,
    input  StoreUop    store,
    output logic       stStall,
    input  logic       commitValid,
    input  SqN         commitSqN,
    input  BranchFlush branch,
    input  Addr        lookupAddr,
    input  SqN         lookupSqN,
    output FwdLookup   fwd,
    output MemReq      drainReq,
    input  logic       drainGrant
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    StoreUop entries [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic push;
    logic retire;
    logic [CNT_W-1:0] keepCnt;
    logic [PTR_W-1:0] tailBase;
    logic [CNT_W-1:0] countBase;

    assign stStall = (count == CNT_W'(DEPTH));
    assign push = store.valid && !stStall && !(branch.taken && isYounger(store.sqN, branch.sqN));
    assign retire = drainReq.valid && drainGrant;

    // the head entry goes to memory once the core has committed it.
    always_comb begin
        drainReq.valid = (count != '0) && commitValid && !isYounger(entries[head].sqN, commitSqN);
        drainReq.we = 1'b1;
        drainReq.wordAddr = entries[head].addr[31:2];
        drainReq.wdata = entries[head].data;
        drainReq.wmask = entries[head].wmask;
    end

    // entries sit in age order, so the survivors of a flush form a prefix from the head.
    always_comb begin
        logic [PTR_W-1:0] idx;
        keepCnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = head + PTR_W'(i);
            if (CNT_W'(i) < count && !isYounger(entries[idx].sqN, branch.sqN)) begin
                keepCnt = CNT_W'(i + 1);
            end
        end
    end

    assign tailBase = branch.taken ? head + keepCnt[PTR_W-1:0] : tail;
    assign countBase = branch.taken ? keepCnt : count;

    // walk oldest to youngest so the youngest matching store wins each lane.
    always_comb begin
        logic [PTR_W-1:0] idx;
        fwd = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = head + PTR_W'(i);
            if (CNT_W'(i) < count && entries[idx].addr[31:2] == lookupAddr[31:2]
                    && !isYounger(entries[idx].sqN, lookupSqN)) begin
                for (int b = 0; b < 4; b++) begin
                    if (entries[idx].wmask[b]) begin
                        fwd.mask[b] = 1'b1;
                        fwd.data[8*b +: 8] = entries[idx].data[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head + 1'b1;
            end
            tail <= tailBase + PTR_W'(push);
            count <= countBase + CNT_W'(push) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tailBase] <= store;
        end
    end

endmodule

// File: verif/lsuTb.sv
`timescale 1ns/1ns
`include "lsu_settings.svh"

module lsuTb import lsuPkg::*; ();

    localparam int TIMEOUT = 20;

    logic clk;
    logic rst;
    LoadUop load;
    StoreUop store;
    logic stStall;
    logic commitValid;
    SqN commitSqN;
    BranchFlush branch;
    LoadResult result;

    integer seed;
    int errors;
    int checks;
    SqN lastSqN;
    Word refMem [`LSU_RAM_WORDS];
    StoreUop pending [$];

    lsuTop u_dut (
        .clk(clk),
        .rst(rst),
        .load(load),
        .store(store),
        .stStall(stStall),
        .commitValid(commitValid),
        .commitSqN(commitSqN),
        .branch(branch),
        .result(result)
    );

    always #50 clk = ~clk;

    // the oldest store in the model is written to memory on each drain grant.
    always @(negedge clk) begin
        if (!rst && u_dut.drainGrant) begin
            if (pending.size() == 0) begin
                errors++;
                $display("drain grant at %0t with no store left in the model", $time);
            end else begin
                applyStore(pending.pop_front());
            end
        end
    end

    function automatic logic isAfter(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return (diff != '0) && !diff[`LSU_SQN_W-1];
    endfunction

    // the expected word is memory with every queued store that the load may see laid over it.
    function automatic Word expectedLoad(Addr addr, LoadSize size, logic signExtend, SqN sqN);
        Word w;
        Word shifted;
        w = refMem[addr[9:2]];
        foreach (pending[i]) begin
            if (pending[i].addr[31:2] == addr[31:2] && !isAfter(pending[i].sqN, sqN)) begin
                for (int b = 0; b < 4; b++) begin
                    if (pending[i].wmask[b]) begin
                        w[8*b +: 8] = pending[i].data[8*b +: 8];
                    end
                end
            end
        end
        shifted = w >> (8 * addr[1:0]);
        if (size == SIZE_BYTE) begin
            return signExtend ? {{24{shifted[7]}}, shifted[7:0]} : {24'b0, shifted[7:0]};
        end else if (size == SIZE_HALF) begin
            return signExtend ? {{16{shifted[15]}}, shifted[15:0]} : {16'b0, shifted[15:0]};
        end
        return w;
    endfunction

    task automatic applyStore(StoreUop st);
        for (int b = 0; b < 4; b++) begin
            if (st.wmask[b]) begin
                refMem[st.addr[9:2]][8*b +: 8] = st.data[8*b +: 8];
            end
        end
    endtask

    task automatic dropYounger(SqN branchSqN);
        StoreUop kept [$];
        foreach (pending[i]) begin
            if (!isAfter(pending[i].sqN, branchSqN)) begin
                kept.push_back(pending[i]);
            end
        end
        pending = kept;
    endtask

    task automatic compareValue(string name, Word got, Word exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic reportTimeout(string what);
        errors++;
        $display("no progress after %0d cycles while waiting for %s", TIMEOUT, what);
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #5;
    endtask

    task automatic sendStore(Addr addr, Word data, ByteMask mask);
        StoreUop st;
        int waited;
        st.valid = 1'b1;
        st.addr = addr;
        st.data = data;
        st.wmask = mask;
        st.sqN = lastSqN + 1'b1;
        store = st;
        waited = 0;
        while (stStall) begin
            nextCycle();
            waited++;
            if (waited > TIMEOUT) begin
                reportTimeout("store acceptance");
                break;
            end
        end
        pending.push_back(st);
        lastSqN = st.sqN;
        nextCycle();
        store = '0;
    endtask

    task automatic commitAll();
        int waited;
        commitSqN = lastSqN;
        waited = 0;
        while (pending.size() > 0) begin
            nextCycle();
            waited++;
            if (waited > TIMEOUT) begin
                reportTimeout("store drain");
                break;
            end
        end
    endtask

    task automatic checkLoad(Addr addr, LoadSize size, logic sext, Tag tag, int expLatency);
        LoadUop ld;
        Word exp;
        int waited;
        ld.valid = 1'b1;
        ld.addr = addr;
        ld.size = size;
        ld.signExtend = sext;
        ld.tagDst = tag;
        ld.sqN = lastSqN;
        exp = expectedLoad(addr, size, sext, lastSqN);
        load = ld;
        waited = 0;
        do begin
            nextCycle();
            load = '0;
            waited++;
            if (waited > TIMEOUT) begin
                reportTimeout("a load result");
                break;
            end
        end while (!result.valid);
        compareValue("result.result", result.result, exp);
        compareValue("result.tagDst", Word'(result.tagDst), Word'(tag));
        compareValue("result.sqN", Word'(result.sqN), Word'(ld.sqN));
        compareValue("load latency", Word'(waited), Word'(expLatency));
    endtask

    task automatic storeThenLoad();
        sendStore(32'h40, $random(seed), 4'hF);
        commitAll();
        checkLoad(32'h40, SIZE_WORD, 1'b0, 6'd5, 2);
        checkLoad(32'h40, SIZE_WORD, 1'b1, 6'd9, 2);
    endtask

    task automatic byteAndHalfLoads();
        sendStore(32'h60, 32'h7F85C314, 4'hF);
        commitAll();
        for (int off = 0; off < 4; off++) begin
            checkLoad(32'h60 + off, SIZE_BYTE, 1'b0, Tag'(off), 2);
            checkLoad(32'h60 + off, SIZE_BYTE, 1'b1, Tag'(off + 4), 2);
        end
        for (int off = 0; off < 4; off += 2) begin
            checkLoad(32'h60 + off, SIZE_HALF, 1'b0, Tag'(off + 8), 2);
            checkLoad(32'h60 + off, SIZE_HALF, 1'b1, Tag'(off + 9), 2);
        end
    endtask

    task automatic fullForwarding();
        sendStore(32'h44, $random(seed), 4'hF);
        checkLoad(32'h44, SIZE_WORD, 1'b0, 6'd12, 1);
        checkLoad(32'h46, SIZE_HALF, 1'b1, 6'd13, 1);
        commitAll();
    endtask

    task automatic partialForwarding();
        sendStore(32'h48, $random(seed), 4'hF);
        commitAll();
        sendStore(32'h48, $random(seed), 4'b0101);
        checkLoad(32'h48, SIZE_WORD, 1'b0, 6'd20, 2);
        checkLoad(32'h49, SIZE_BYTE, 1'b1, 6'd21, 2);
        commitAll();
        checkLoad(32'h48, SIZE_WORD, 1'b0, 6'd22, 2);
    endtask

    task automatic flushOnBranch();
        LoadUop older;
        LoadUop younger;
        SqN keepSqN;
        Word exp;
        sendStore(32'h4C, $random(seed), 4'hF);
        keepSqN = lastSqN;
        sendStore(32'h4C, $random(seed), 4'hF);
        older = '{valid: 1'b1, addr: 32'h40, size: SIZE_WORD, signExtend: 1'b0,
                  tagDst: 6'd30, sqN: keepSqN};
        exp = expectedLoad(32'h40, SIZE_WORD, 1'b0, keepSqN);
        load = older;
        nextCycle();
        younger = '{valid: 1'b1, addr: 32'h4C, size: SIZE_WORD, signExtend: 1'b0,
                    tagDst: 6'd31, sqN: lastSqN};
        load = younger;
        branch.taken = 1'b1;
        branch.sqN = keepSqN;
        dropYounger(keepSqN);
        lastSqN = keepSqN;
        nextCycle();
        load = '0;
        branch = '0;
        checks++;
        if (!result.valid) begin
            errors++;
            $display("the older load gave no result two cycles after it was issued");
        end else begin
            compareValue("result.result", result.result, exp);
            compareValue("result.tagDst", Word'(result.tagDst), 32'd30);
            compareValue("result.sqN", Word'(result.sqN), Word'(keepSqN));
        end
        for (int i = 0; i < 4; i++) begin
            nextCycle();
            checks++;
            if (result.valid) begin
                errors++;
                $display("a flushed load still wrote back tag %0d", result.tagDst);
            end
        end
        commitAll();
        checkLoad(32'h4C, SIZE_WORD, 1'b0, 6'd33, 2);
    endtask

    task automatic queueFullStall();
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            sendStore(32'h80 + 4 * i, $random(seed), 4'hF);
        end
        compareValue("stStall", Word'(stStall), 32'd1);
        // without commitValid the head stays in the queue.
        commitValid = 1'b0;
        commitSqN = lastSqN;
        nextCycle();
        compareValue("stStall", Word'(stStall), 32'd1);
        commitValid = 1'b1;
        sendStore(32'h90, $random(seed), 4'hF);
        commitAll();
        compareValue("stStall", Word'(stStall), 32'd0);
        checkLoad(32'h80, SIZE_WORD, 1'b0, 6'd40, 2);
        checkLoad(32'h90, SIZE_WORD, 1'b0, 6'd41, 2);
    endtask

    initial begin
        seed = 29612;
        errors = 0;
        checks = 0;
        lastSqN = '0;
        clk = 1'b0;
        rst = 1'b1;
        load = '0;
        store = '0;
        commitValid = 1'b1;
        commitSqN = '0;
        branch = '0;
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            refMem[i] = '0;
        end
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        compareValue("result.valid", Word'(result.valid), 32'd0);
        compareValue("stStall", Word'(stStall), 32'd0);

        storeThenLoad();
        byteAndHalfLoads();
        fullForwarding();
        partialForwarding();
        flushOnBranch();
        queueFullStall();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
